// File: Makefile
VERILATOR ?= verilator
TOP       ?= mutative_cache_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+design
design/mutative_types.sv
design/mutative_mem_types.sv
design/mutative_plru.sv
design/mutative_line_store.sv
design/mutative_cache_ctrl.sv
design/mutative_cache.sv
verif/mutative_cache_checker.sv
verif/mutative_cache_tb.sv

// File: design/mutative_cache.sv
`timescale 1ns/10ps
`default_nettype none

module mutative_cache (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire mutative_types::assoc_mode_t    setup,
    input  wire                                 req_valid,
    input  wire mutative_types::cache_address_t req_addr,
    output logic                                req_ready,
    output logic                                rsp_valid,
    output mutative_mem_types::mem_data_t       rsp_data,
    output logic                                rsp_hit,
    output logic                                mem_req_valid,
    output mutative_mem_types::mem_addr_t       mem_req_addr,
    input  wire                                 mem_credit,
    input  wire                                 mem_rsp_valid,
    input  wire mutative_mem_types::mem_data_t  mem_rsp_data
);
    import mutative_types::*;
    import mutative_mem_types::*;

    cache_address_t lookup_addr;
    logic           hit;
    way_idx_t       hit_way;
    mem_data_t      hit_data;
    way_idx_t       evict_way;
    logic           touch;
    way_idx_t       touch_way;
    logic           fill_we;
    way_idx_t       fill_way;
    mem_data_t      fill_data;

    mutative_cache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .hit           (hit),
        .hit_way       (hit_way),
        .hit_data      (hit_data),
        .evict_way     (evict_way),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .req_ready     (req_ready),
        .lookup_addr   (lookup_addr),
        .touch         (touch),
        .touch_way     (touch_way),
        .fill_we       (fill_we),
        .fill_way      (fill_way),
        .fill_data     (fill_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_hit       (rsp_hit)
    );

    mutative_line_store u_line_store (
        .clk         (clk),
        .rst         (rst),
        .setup       (setup),
        .lookup_addr (lookup_addr),
        .fill_we     (fill_we),
        .fill_way    (fill_way),
        .fill_data   (fill_data),
        .hit         (hit),
        .hit_way     (hit_way),
        .hit_data    (hit_data)
    );

    mutative_plru u_plru (
        .clk         (clk),
        .rst         (rst),
        .setup       (setup),
        .lookup_addr (lookup_addr),
        .touch       (touch),
        .touch_way   (touch_way),
        .evict_way   (evict_way)
    );

endmodule

`default_nettype wire

// File: design/mutative_cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "mutative_consts.svh"

module mutative_cache_ctrl (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 req_valid,
    input  wire mutative_types::cache_address_t req_addr,
    input  wire                                 hit,
    input  wire mutative_types::way_idx_t       hit_way,
    input  wire mutative_mem_types::mem_data_t  hit_data,
    input  wire mutative_types::way_idx_t       evict_way,
    input  wire                                 mem_credit,
    input  wire                                 mem_rsp_valid,
    input  wire mutative_mem_types::mem_data_t  mem_rsp_data,
    output logic                                req_ready,
    output mutative_types::cache_address_t      lookup_addr,
    output logic                                touch,
    output mutative_types::way_idx_t            touch_way,
    output logic                                fill_we,
    output mutative_types::way_idx_t            fill_way,
    output mutative_mem_types::mem_data_t       fill_data,
    output logic                                mem_req_valid,
    output mutative_mem_types::mem_addr_t       mem_req_addr,
    output logic                                rsp_valid,
    output mutative_mem_types::mem_data_t       rsp_data,
    output logic                                rsp_hit
);
    import mutative_types::*;
    import mutative_mem_types::*;

    ctrl_state_t    state_q;
    ctrl_state_t    state_d;
    cache_address_t addr_q;
    way_idx_t       victim_q;
    mem_data_t      fill_data_q;
    credit_cnt_t    credits_q;
    logic           issue;

    assign issue         = (state_q == st_miss_req) && (credits_q != '0);
    assign mem_req_valid = issue; // one-cycle request
    assign mem_req_addr  = mem_addr_t'(addr_q);
    assign lookup_addr   = addr_q;
    assign fill_we       = (state_q == st_refill_write);
    assign fill_way      = victim_q;
    assign fill_data     = fill_data_q;
    assign touch         = ((state_q == st_lookup) && hit) || fill_we;
    assign touch_way     = fill_we ? victim_q : hit_way;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:         if (req_valid && req_ready) state_d = st_lookup;
            st_lookup:       state_d = hit ? st_idle : st_miss_req;
            st_miss_req:     if (issue) state_d = st_refill_wait;
            st_refill_wait:  if (mem_rsp_valid) state_d = st_refill_write;
            st_refill_write: state_d = st_idle;
            default:         state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= st_idle;
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            credits_q <= credit_cnt_t'(`MUT_MEM_CREDITS);
        end else begin
            state_q   <= state_d;
            req_ready <= (state_d == st_idle);
            rsp_valid <= ((state_q == st_lookup) && hit) || fill_we;
            credits_q <= credits_q + credit_cnt_t'(mem_credit) - credit_cnt_t'(issue);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            addr_q <= req_addr;
        end
        if (state_q == st_lookup && !hit) begin
            victim_q <= evict_way; // held until refill
        end
        if (state_q == st_refill_wait && mem_rsp_valid) begin
            fill_data_q <= mem_rsp_data;
        end
        if (state_q == st_lookup) begin
            rsp_data <= hit_data;
            rsp_hit  <= hit;
        end else if (fill_we) begin
            rsp_data <= fill_data_q;
            rsp_hit  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/mutative_consts.svh
`ifndef MUTATIVE_CONSTS_SVH
`define MUTATIVE_CONSTS_SVH

// cache geometry
`define MUT_WAYS        8
`define MUT_SETS        16
`define MUT_WAY_W       3
`define MUT_SET_W       4
`define MUT_TAG_W       12

// datapath and memory channel
`define MUT_ADDR_W      16
`define MUT_DATA_W      32
`define MUT_CREDIT_W    2
`define MUT_MEM_CREDITS 2

`endif

// File: design/mutative_line_store.sv
`timescale 1ns/10ps
`default_nettype none
`include "mutative_consts.svh"

module mutative_line_store (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire mutative_types::assoc_mode_t    setup,
    input  wire mutative_types::cache_address_t lookup_addr,
    input  wire                                 fill_we,
    input  wire mutative_types::way_idx_t       fill_way,
    input  wire mutative_mem_types::mem_data_t  fill_data,
    output logic                                hit,
    output mutative_types::way_idx_t            hit_way,
    output mutative_mem_types::mem_data_t       hit_data
);
    import mutative_types::*;
    import mutative_mem_types::*;

    set_idx_t   set_idx;
    cache_tag_t tag;
    way_mask_t  grp;
    way_mask_t  valid_q [`MUT_SETS];
    cache_tag_t tag_q   [`MUT_SETS][`MUT_WAYS];
    mem_data_t  data_q  [`MUT_SETS][`MUT_WAYS];

    assign set_idx  = lookup_addr[`MUT_SET_W-1:0];
    assign tag      = lookup_addr[`MUT_ADDR_W-1:`MUT_SET_W];
    assign grp      = group_mask(setup, tag);
    assign hit_data = data_q[set_idx][hit_way];

    // ways outside the group never match
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `MUT_WAYS; w++) begin
            if (grp[w] && valid_q[set_idx][w] && tag_q[set_idx][w] == tag) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `MUT_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill_we) begin
            valid_q[set_idx][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_q[set_idx][fill_way]  <= tag;
            data_q[set_idx][fill_way] <= fill_data;
        end
    end

endmodule

`default_nettype wire

// File: design/mutative_mem_types.sv
`default_nettype none
`include "mutative_consts.svh"

package mutative_mem_types;

    typedef logic [`MUT_ADDR_W-1:0]   mem_addr_t; // word address
    typedef logic [`MUT_DATA_W-1:0]   mem_data_t;
    typedef logic [`MUT_CREDIT_W-1:0] credit_cnt_t;

endpackage

`default_nettype wire

// File: design/mutative_plru.sv
`timescale 1ns/10ps
`default_nettype none
`include "mutative_consts.svh"

module mutative_plru (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire mutative_types::assoc_mode_t    setup,
    input  wire mutative_types::cache_address_t lookup_addr,
    input  wire                                 touch,
    input  wire mutative_types::way_idx_t       touch_way,
    output mutative_types::way_idx_t            evict_way
);
    import mutative_types::*;

    localparam int CNT_W = $clog2(`MUT_WAYS + 1);

    set_idx_t         set_idx;
    cache_tag_t       tag;
    way_mask_t        grp;
    way_mask_t        bits;
    way_mask_t        touch_mask;
    logic [CNT_W-1:0] clear_cnt;
    way_mask_t        mru_q [`MUT_SETS];

    assign set_idx    = lookup_addr[`MUT_SET_W-1:0];
    assign tag        = lookup_addr[`MUT_ADDR_W-1:`MUT_SET_W];
    assign grp        = group_mask(setup, tag);
    assign bits       = mru_q[set_idx];
    assign touch_mask = way_mask_t'(1) << touch_way;

    // clear bits left in the active group
    always_comb begin
        clear_cnt = '0;
        for (int w = 0; w < `MUT_WAYS; w++) begin
            if (grp[w] && !bits[w]) begin
                clear_cnt = clear_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        evict_way = tag[`MUT_WAY_W-1:0]; // direct-mapped way
        if (setup != mode_dm) begin
            for (int w = `MUT_WAYS - 1; w >= 0; w--) begin // lowest clear wins
                if (grp[w] && !bits[w]) begin
                    evict_way = way_idx_t'(w);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `MUT_SETS; s++) begin
                mru_q[s] <= '0;
            end
        end else if (touch && (bits & touch_mask) == '0) begin
            if (clear_cnt == CNT_W'(1)) begin
                mru_q[set_idx] <= (bits & ~grp) | touch_mask; // group wraps
            end else begin
                mru_q[set_idx] <= bits | touch_mask;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mutative_types.sv
`default_nettype none
`include "mutative_consts.svh"

package mutative_types;

    typedef logic [`MUT_WAY_W-1:0]  way_idx_t;
    typedef logic [`MUT_WAYS-1:0]   way_mask_t;
    typedef logic [`MUT_SET_W-1:0]  set_idx_t;   // addr 3:0
    typedef logic [`MUT_TAG_W-1:0]  cache_tag_t; // addr 15:4
    typedef logic [`MUT_ADDR_W-1:0] cache_address_t;

    typedef enum logic [1:0] {
        mode_dm   = 2'b00,
        mode_2way = 2'b01,
        mode_4way = 2'b10,
        mode_8way = 2'b11
    } assoc_mode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_req,
        st_refill_wait,
        st_refill_write
    } ctrl_state_t;

    // ways of the set that the current mode lets this tag use
    function automatic way_mask_t group_mask(assoc_mode_t mode, cache_tag_t tag);
        case (mode)
            mode_dm:   group_mask = way_mask_t'(1) << tag[2:0];
            mode_2way: group_mask = way_mask_t'(2'b11) << {tag[2:1], 1'b0};
            mode_4way: group_mask = way_mask_t'(4'hf) << {tag[2], 2'b00};
            default:   group_mask = '1;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verif/mutative_cache_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "mutative_consts.svh"

module mutative_cache_checker (
    input wire clk,
    input wire rst,
    input wire req_valid,
    input wire req_ready,
    input wire rsp_valid,
    input wire mem_req_valid,
    input wire mem_credit
);
    import mutative_mem_types::*;

    credit_cnt_t credits;
    logic        pending; // accepted but not yet answered
    int          fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_cnt_t'(`MUT_MEM_CREDITS);
            pending <= 1'b0;
        end else begin
            credits <= credits + credit_cnt_t'(mem_credit) - credit_cnt_t'(mem_req_valid);
            pending <= (pending && !rsp_valid) || (req_valid && req_ready);
        end
    end

    credit_guard: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> credits != '0)
        else begin
            $error("memory request issued with no credit left");
            fail_cnt++;
        end

    ready_guard: assert property (@(posedge clk) disable iff (rst)
        pending && !rsp_valid |-> !req_ready)
        else begin
            $error("req_ready high while a response is pending");
            fail_cnt++;
        end

    rsp_pulse: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |=> !rsp_valid)
        else begin
            $error("rsp_valid held longer than one cycle");
            fail_cnt++;
        end

endmodule

bind mutative_cache mutative_cache_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .mem_req_valid (mem_req_valid),
    .mem_credit    (mem_credit)
);

`default_nettype wire

// File: verif/mutative_cache_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mutative_consts.svh"

module mutative_cache_tb;
    import mutative_types::*;
    import mutative_mem_types::*;

    localparam int WAIT_LIMIT = 200;

    logic           clk           = 1'b0;
    logic           rst           = 1'b1;
    assoc_mode_t    setup         = mode_dm;
    logic           req_valid     = 1'b0;
    cache_address_t req_addr      = '0;
    logic           mem_credit    = 1'b0;
    logic           mem_rsp_valid = 1'b0;
    mem_data_t      mem_rsp_data  = '0;
    logic           req_ready;
    logic           rsp_valid;
    mem_data_t      rsp_data;
    logic           rsp_hit;
    logic           mem_req_valid;
    mem_addr_t      mem_req_addr;

    logic [31:0] rng        = 32'hba635723;
    int          cyc        = 0;
    int          rsp_due    = -1; // negedge count of the pending memory answer
    int          credit_lag = 0;
    mem_addr_t   rsp_addr   = '0;
    int          credit_due[$];
    int          errors     = 0;
    int          failures   = 0;

    mutative_cache u_mutative_cache (
        .clk           (clk),
        .rst           (rst),
        .setup         (setup),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_hit       (rsp_hit),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_credit    (mem_credit),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory model answers each request after 1 to 4 cycles
    always @(negedge clk) begin
        mem_rsp_valid = 1'b0;
        mem_credit    = 1'b0;
        cyc           = cyc + 1;
        if (rsp_due == cyc) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = 32'h5a5a0000 ^ mem_data_t'(rsp_addr);
            credit_due.push_back(cyc + credit_lag);
            rsp_due = -1;
        end
        if (credit_due.size() > 0 && credit_due[0] <= cyc) begin
            mem_credit = 1'b1; // one credit per cycle
            void'(credit_due.pop_front());
        end
        if (mem_req_valid) begin
            rng      = xorshift(rng);
            rsp_due  = cyc + 1 + int'(rng % 4);
            rsp_addr = mem_req_addr;
        end
    end

    task automatic apply_reset(assoc_mode_t mode);
        int n;
        n = 0;
        while ((credit_due.size() > 0 || rsp_due >= 0) && n < WAIT_LIMIT) begin
            @(negedge clk); // let the memory hand back every credit
            n++;
        end
        if (credit_due.size() > 0 || rsp_due >= 0) begin
            $display("timeout: memory credits still outstanding before reset");
            failures++;
        end
        setup = mode;
        rst   = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic do_read(string name, cache_address_t addr, logic exp_hit,
                           mem_data_t exp_data);
        int n;
        n         = 0;
        req_valid = 1'b1;
        req_addr  = addr;
        while (!req_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            $display("timeout: %s was never accepted", name);
            failures++;
            req_valid = 1'b0;
            return;
        end
        n = 0;
        do begin
            @(negedge clk);
            req_valid = 1'b0;
            n++;
        end while (!rsp_valid && n < WAIT_LIMIT);
        if (!rsp_valid) begin
            $display("timeout: %s got no response", name);
            failures++;
        end else begin
            assert (rsp_hit == exp_hit) else begin
                $display("ERROR %s hit: expected %0d, actual %0d", name, exp_hit, rsp_hit);
                errors++;
            end
            assert (rsp_data == exp_data) else begin
                $display("ERROR %s data: expected %h, actual %h", name, exp_data, rsp_data);
                errors++;
            end
            if (exp_hit) begin
                assert (n == 2) else begin
                    $display("ERROR %s hit latency: expected 2, actual %0d", name, n);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        int          fd;
        int          idx;
        int          prev_setup;
        int          f_setup;
        int          f_hit;
        int          f_lag;
        int          assert_fails;
        logic [15:0] f_addr;
        logic [31:0] f_data;
        string       line;
        idx        = 0;
        prev_setup = -1;
        fd = $fopen("verif/mutative_cache_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            failures++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;
            if ($sscanf(line, "%h %h %h %h %d", f_setup, f_addr, f_hit, f_data, f_lag) != 5) begin
                $display("malformed stimulus line: %s", line);
                failures++;
                continue;
            end
            if (f_setup != prev_setup) begin
                apply_reset(assoc_mode_t'(f_setup[1:0])); // new mode starts cold
                prev_setup = f_setup;
            end
            credit_lag = f_lag;
            idx++;
            do_read($sformatf("read%0d_mode%0d_%h", idx, f_setup, f_addr),
                    f_addr, f_hit[0], f_data);
        end
        if (fd != 0) $fclose(fd);
        assert_fails = u_mutative_cache.u_checker.fail_cnt;
        $display("summary: %0d mismatches, %0d other failures, %0d assertion failures over %0d reads",
                 errors, failures, assert_fails, idx);
        if (errors == 0 && failures == 0 && assert_fails == 0 && idx > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/mutative_cache_testdata.txt
# setup addr hit data credit_lag (hex, hex, 0/1, hex, decimal)
# setup 0 dm, 1 2-way, 2 4-way, 3 8-way; credit_lag = cycles from memory answer to credit
0 0010 0 5a5a0010 0
0 0010 1 5a5a0010 0
0 0090 0 5a5a0090 0
0 0010 0 5a5a0010 0
0 0020 0 5a5a0020 0
0 0010 1 5a5a0010 0
0 0020 1 5a5a0020 0
1 0023 0 5a5a0023 0
1 0003 0 5a5a0003 0
1 0083 0 5a5a0083 0
1 0103 0 5a5a0103 0
1 0083 1 5a5a0083 0
1 0023 1 5a5a0023 0
1 0003 0 5a5a0003 0
2 0045 0 5a5a0045 0
2 0005 0 5a5a0005 0
2 0005 1 5a5a0005 0
2 0045 1 5a5a0045 0
3 0007 0 5a5a0007 20
3 0017 0 5a5a0017 20
3 0027 0 5a5a0027 20
3 0037 0 5a5a0037 20
3 0047 0 5a5a0047 20
3 0057 0 5a5a0057 20
3 0067 0 5a5a0067 20
3 0077 0 5a5a0077 20
3 0017 1 5a5a0017 0
3 0037 1 5a5a0037 0
3 0087 0 5a5a0087 0
3 0007 0 5a5a0007 0
3 0027 0 5a5a0027 0
